//--- include/pce_io_config.svh
`ifndef PCE_IO_CONFIG_SVH
`define PCE_IO_CONFIG_SVH

// ====================
// Host side
// ====================

// One joystick word from the host
`define PCE_JOY_W 32

// Ports on the five-way turbo tap
`define PCE_PAD_PORTS 5

// ====================
// Backup RAM
// ====================

`define PCE_BRM_AW 11   // 2 KiB console window
`define PCE_SECT_AW 9   // Byte address inside one SD sector
`define PCE_SECTORS 4   // Sectors per save image

// Mouse inactivity timer, saturates at all ones
`define PCE_MOUSE_TO_W 15

`endif

//--- src/pce_io_pkg.sv
package pce_io_pkg;

	// ====================
	// FSM and counters
	// ====================

	// Backup sequencer
	typedef enum logic {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1
	} bk_state_t;

	// Which delta nibble the mouse presents next
	typedef enum logic [1:0] {
		MS_X_HI = 2'd0,
		MS_X_LO = 2'd1,
		MS_Y_HI = 2'd2,
		MS_Y_LO = 2'd3
	} ms_nib_t;

	// ====================
	// Pad words
	// ====================

	typedef logic [3:0] pad_nib_t;   // Active low nibble seen by the console
	typedef logic [11:0] pad_word_t; // Three nibbles of one remapped pad
	typedef logic [2:0] tap_port_t;  // Turbo tap port index

endpackage

//--- src/sd_buf_if.sv
`include "pce_io_config.svh"

interface sd_buf_if;

	logic [$clog2(`PCE_SECTORS)-1:0] sector;     // Current sector of the image
	logic [`PCE_SECT_AW-1:0]         buff_addr;  // Byte inside the sector
	logic                            buff_wr;
	logic                            ack;
	logic [7:0]                      buff_dout;  // Host to memory
	logic [7:0]                      buff_din;   // Memory to host

	modport seq (output sector, input ack);

	modport mem (input sector, buff_addr, buff_wr, ack, buff_dout, output buff_din);

	// Top level side, fed from the SD host ports
	modport host (output buff_addr, buff_wr, ack, buff_dout, input buff_din);

endinterface

//--- src/pad_mux.sv
`include "pce_io_config.svh"

module pad_mux import pce_io_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic [`PCE_JOY_W-1:0] joy_a,
	input  logic [`PCE_JOY_W-1:0] joy_b,
	input  logic [`PCE_JOY_W-1:0] joy_2,
	input  logic [`PCE_JOY_W-1:0] joy_3,
	input  logic [`PCE_JOY_W-1:0] joy_4,
	input  logic                  joy_swap,
	input  logic                  turbotap,
	input  logic                  buttons6,
	input  logic                  mouse_en,
	input  logic                  sel,
	input  logic                  clr,
	input  logic [7:0]            mouse_byte,
	output logic [`PCE_JOY_W-1:0] joy_0,     // Player one after swap, for the mouse
	output pad_nib_t              pad_in
);

	logic [`PCE_JOY_W-1:0] joy_1;
	logic [`PCE_JOY_W-1:0] tap_word [`PCE_PAD_PORTS];
	logic [15:0]           pad_data;
	tap_port_t             port;
	logic                  high_bank;
	logic                  sel_d;
	logic                  clr_d;

	// Host word to console pad, buttons low nibble, dpad middle, III-VI on top
	function automatic pad_word_t remap(input logic [`PCE_JOY_W-1:0] joy);
		return ~{joy[11:8], joy[1], joy[2], joy[0], joy[3], joy[7:4]};
	endfunction

	assign joy_0 = joy_swap ? joy_b : joy_a;
	assign joy_1 = joy_swap ? joy_a : joy_b;

	assign tap_word[0] = joy_0;
	assign tap_word[1] = joy_1;
	assign tap_word[2] = joy_2;
	assign tap_word[3] = joy_3;
	assign tap_word[4] = joy_4;

	// ====================
	// Port select
	// ====================

	always_comb begin
		if (port >= tap_port_t'(`PCE_PAD_PORTS)) begin
			pad_data = 16'h0FFF;  // Empty tap slot
		end else if (port == '0 && mouse_en) begin
			pad_data = {mouse_byte, mouse_byte};
		end else begin
			// Top nibble stays 0, the 6-button signature
			pad_data = {4'h0, remap(tap_word[port])};
		end
	end

	// ====================
	// Pad latch
	// ====================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pad_in    <= '0;
			port      <= '0;
			high_bank <= 1'b0;
			sel_d     <= 1'b0;
			clr_d     <= 1'b0;
		end else begin
			sel_d  <= sel;
			clr_d  <= clr;
			pad_in <= pad_data[{high_bank, sel, 2'b00} +: 4];

			if (clr) begin
				port   <= '0;
				pad_in <= '0;
				// Bank flips once per clr pulse
				if (!clr_d)
					high_bank <= !high_bank && buttons6;
			end else if (sel && !sel_d && turbotap) begin
				port <= port + tap_port_t'(1);  // Walk the tap
			end
		end
	end

endmodule

//--- src/mouse_track.sv
`include "pce_io_config.svh"

module mouse_track import pce_io_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  clr,
	input  logic [`PCE_JOY_W-1:0] joy_0,
	input  logic [8:0]            mouse_x,
	input  logic [8:0]            mouse_y,
	input  logic [7:0]            mouse_flags,  // Bit 0 left, bit 1 right
	input  logic                  mouse_strobe,
	output logic [7:0]            mouse_byte
);

	ms_nib_t                    nib;
	logic [`PCE_MOUSE_TO_W-1:0] idle_cnt;
	logic                       clr_d;
	logic [7:0]                 acc_x;
	logic [7:0]                 acc_y;
	logic [7:0]                 ms_x;  // Deltas the console is reading
	logic [7:0]                 ms_y;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			nib      <= MS_Y_LO;
			idle_cnt <= '0;
			clr_d    <= 1'b0;
			acc_x    <= '0;
			acc_y    <= '0;
			ms_x     <= '0;
			ms_y     <= '0;
		end else begin
			clr_d <= clr;

			if (clr)
				idle_cnt <= '0;
			else if (!(&idle_cnt))
				idle_cnt <= idle_cnt + 1'b1;

			// Console went quiet, next clr restarts at the x high nibble
			if (&idle_cnt)
				nib <= MS_Y_LO;

			if (clr && !clr_d) begin
				nib <= ms_nib_t'(nib + 2'd1);
				if (nib == MS_Y_LO) begin
					ms_x  <= acc_x;
					ms_y  <= acc_y;
					acc_x <= '0;
					acc_y <= '0;
				end
			end

			// New host report wins over the clear above
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_x[7:0];
				acc_y <= mouse_y[7:0];
			end
		end
	end

	always_comb begin
		mouse_byte[3:0] = ~{joy_0[7:6], mouse_flags[0], mouse_flags[1]};
		case (nib)
			MS_X_HI: mouse_byte[7:4] = ms_x[7:4];
			MS_X_LO: mouse_byte[7:4] = ms_x[3:0];
			MS_Y_HI: mouse_byte[7:4] = ms_y[7:4];
			MS_Y_LO: mouse_byte[7:4] = ms_y[3:0];
		endcase
	end

endmodule

//--- src/backup_ram.sv
`include "pce_io_config.svh"

module backup_ram (
	input  logic                   clk_sys,
	input  logic [`PCE_BRM_AW-1:0] brm_addr,
	input  logic                   brm_we,
	input  logic [7:0]             brm_wdata,
	output logic [7:0]             brm_rdata,
	sd_buf_if.mem                  sd
);

	localparam int DEPTH = 2 ** `PCE_BRM_AW;

	logic [7:0]             mem [DEPTH];
	logic [`PCE_BRM_AW-1:0] sd_addr;

	// Sector picks the 512 byte slice
	assign sd_addr = {sd.sector, sd.buff_addr};

	// ====================
	// Both ports
	// ====================

	always_ff @(posedge clk_sys) begin
		// Console side
		if (brm_we)
			mem[brm_addr] <= brm_wdata;
		brm_rdata <= mem[brm_addr];

		// SD side, writes only while the host holds ack
		if (sd.buff_wr && sd.ack)
			mem[sd_addr] <= sd.buff_dout;
		sd.buff_din <= mem[sd_addr];  // Old data on a same cycle write
	end

endmodule

//--- src/backup_sync.sv
`include "pce_io_config.svh"

module backup_sync import pce_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        download,
	input  logic        mount_strobe,
	input  logic [31:0] img_size,
	input  logic        bk_save,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_reset,
	sd_buf_if.seq       sd
);

	localparam int SECT_W = $clog2(`PCE_SECTORS);

	bk_state_t state;
	logic      bk_ena;   // An image is mounted
	logic      bk_load;  // Load pending or running
	logic      old_download;
	logic      old_mount;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      ack_rise;
	logic      ack_fall;
	logic      start;

	assign ack_rise = sd_ack && !old_ack;
	assign ack_fall = !sd_ack && old_ack;
	assign start    = bk_ena && ((bk_load && !old_load) || (bk_save && !old_save));

	assign sd.sector = sd_lba[SECT_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state        <= BK_IDLE;
			bk_ena       <= 1'b0;
			bk_load      <= 1'b0;
			bk_reset     <= 1'b0;
			sd_rd        <= 1'b0;
			sd_wr        <= 1'b0;
			sd_lba       <= '0;
			old_download <= 1'b0;
			old_mount    <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_ack      <= 1'b0;
		end else begin
			bk_reset     <= 1'b0;
			old_download <= download;
			old_mount    <= mount_strobe;
			old_load     <= bk_load;
			old_save     <= bk_save;
			old_ack      <= sd_ack;

			// New cartridge, old save no longer belongs to it
			if (download && !old_download)
				bk_ena <= 1'b0;

			if (mount_strobe && !old_mount && |img_size) begin
				bk_ena  <= 1'b1;
				bk_load <= 1'b1;
			end

			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			// ====================
			// Sector FSM
			// ====================
			case (state)
				BK_IDLE: begin
					if (start) begin
						state  <= BK_XFER;
						sd_lba <= '0;
						sd_rd  <= bk_load;
						sd_wr  <= !bk_load;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						if (sd.sector == SECT_W'(`PCE_SECTORS - 1)) begin
							bk_reset <= bk_load;  // Restart the console on fresh data
							bk_load  <= 1'b0;
							state    <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_load;
							sd_wr  <= !bk_load;
						end
					end
				end
			endcase
		end
	end

endmodule

//--- src/pce_io_top.sv
`include "pce_io_config.svh"

module pce_io_top import pce_io_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	// Joypad port
	input  logic [`PCE_JOY_W-1:0]  joy_a,
	input  logic [`PCE_JOY_W-1:0]  joy_b,
	input  logic [`PCE_JOY_W-1:0]  joy_2,
	input  logic [`PCE_JOY_W-1:0]  joy_3,
	input  logic [`PCE_JOY_W-1:0]  joy_4,
	input  logic                   joy_swap,
	input  logic                   turbotap,
	input  logic                   buttons6,
	input  logic                   mouse_en,
	input  logic                   sel,
	input  logic                   clr,
	output pad_nib_t               pad_in,
	// Mouse
	input  logic [8:0]             mouse_x,
	input  logic [8:0]             mouse_y,
	input  logic [7:0]             mouse_flags,
	input  logic                   mouse_strobe,
	// Console backup RAM port
	input  logic [`PCE_BRM_AW-1:0] brm_addr,
	input  logic                   brm_we,
	input  logic [7:0]             brm_wdata,
	output logic [7:0]             brm_rdata,
	// Image control
	input  logic                   download,
	input  logic                   mount_strobe,
	input  logic [31:0]            img_size,
	input  logic                   bk_save,
	output logic                   bk_reset,
	// SD host
	input  logic                   sd_ack,
	input  logic [`PCE_SECT_AW-1:0] sd_buff_addr,
	input  logic                   sd_buff_wr,
	input  logic [7:0]             sd_buff_dout,
	output logic [7:0]             sd_buff_din,
	output logic [31:0]            sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr
);

	logic [`PCE_JOY_W-1:0] joy_0;
	logic [7:0]            mouse_byte;

	sd_buf_if sd_if ();

	// ====================
	// SD host side
	// ====================
	assign sd_if.buff_addr = sd_buff_addr;
	assign sd_if.buff_wr   = sd_buff_wr;
	assign sd_if.ack       = sd_ack;
	assign sd_if.buff_dout = sd_buff_dout;
	assign sd_buff_din     = sd_if.buff_din;

	pad_mux i_pad_mux (
		.clk_sys(clk_sys), .rst(rst),
		.joy_a(joy_a), .joy_b(joy_b), .joy_2(joy_2), .joy_3(joy_3), .joy_4(joy_4),
		.joy_swap(joy_swap), .turbotap(turbotap), .buttons6(buttons6),
		.mouse_en(mouse_en), .sel(sel), .clr(clr),
		.mouse_byte(mouse_byte), .joy_0(joy_0), .pad_in(pad_in)
	);

	mouse_track i_mouse_track (
		.clk_sys(clk_sys), .rst(rst), .clr(clr), .joy_0(joy_0),
		.mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_flags(mouse_flags),
		.mouse_strobe(mouse_strobe), .mouse_byte(mouse_byte)
	);

	backup_ram i_backup_ram (
		.clk_sys(clk_sys), .brm_addr(brm_addr), .brm_we(brm_we),
		.brm_wdata(brm_wdata), .brm_rdata(brm_rdata), .sd(sd_if.mem)
	);

	backup_sync i_backup_sync (
		.clk_sys(clk_sys), .rst(rst), .download(download),
		.mount_strobe(mount_strobe), .img_size(img_size), .bk_save(bk_save),
		.sd_ack(sd_ack), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_reset(bk_reset), .sd(sd_if.seq)
	);

endmodule

//--- verification/pce_io_asserts.sv
module pce_io_asserts (
	input logic clk_sys,
	input logic rst,
	input logic sd_ack,
	input logic sd_rd,
	input logic sd_wr,
	input logic bk_reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// ====================
	// SD request lines
	// ====================

	a_req_excl: assert property (@(posedge clk_sys) disable iff (rst)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high in the same cycle");

	// Host ack takes the request down
	a_req_drop: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(sd_ack) |=> !(sd_rd || sd_wr))
		else $error("SD request still high one cycle after ack rose");

	a_reset_pulse: assert property (@(posedge clk_sys) disable iff (rst)
		bk_reset |=> !bk_reset)
		else $error("bk_reset high for two cycles in a row");

endmodule

bind pce_io_top pce_io_asserts i_asserts (
	.clk_sys(clk_sys),
	.rst(rst),
	.sd_ack(sd_ack),
	.sd_rd(sd_rd),
	.sd_wr(sd_wr),
	.bk_reset(bk_reset)
);

//--- verification/pce_io_tb.sv
`include "pce_io_config.svh"

module pce_io_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 10;
	localparam int N_RAND     = 200;
	localparam int MAX_DELAY  = 15;   // Longest host ack latency in cycles
	localparam int MOUSE_WAIT = 2 ** `PCE_MOUSE_TO_W + 16;
	localparam int BRM_BYTES  = 2 ** `PCE_BRM_AW;
	localparam int SECT_BYTES = 2 ** `PCE_SECT_AW;
	localparam int PAD_CYCLES = 3 * (N_RAND + 120);
	localparam int SD_CYCLES  = 2 * `PCE_SECTORS * (SECT_BYTES + MAX_DELAY + 8);
	localparam int RUN_CYCLES = PAD_CYCLES + MOUSE_WAIT + SD_CYCLES + 3 * BRM_BYTES;

	logic                   clk_sys = 1'b0;
	logic                   rst;
	logic [`PCE_JOY_W-1:0]  joy_a, joy_b, joy_2, joy_3, joy_4;
	logic                   joy_swap, turbotap, buttons6, mouse_en;
	logic                   sel, clr;
	logic [3:0]             pad_in;
	logic [8:0]             mouse_x, mouse_y;
	logic [7:0]             mouse_flags;
	logic                   mouse_strobe;
	logic [`PCE_BRM_AW-1:0] brm_addr;
	logic                   brm_we;
	logic [7:0]             brm_wdata, brm_rdata;
	logic                   download, mount_strobe, bk_save, bk_reset;
	logic [31:0]            img_size;
	logic                   sd_ack;
	logic [`PCE_SECT_AW-1:0] sd_buff_addr;
	logic                   sd_buff_wr;
	logic [7:0]             sd_buff_dout, sd_buff_din;
	logic [31:0]            sd_lba;
	logic                   sd_rd, sd_wr;

	// Reference model state
	logic [31:0] lfsr;
	logic [2:0]  m_port;
	logic        m_bank;
	logic        m_sel_prev;
	logic        m_clr_prev;
	logic [1:0]  m_nib;
	logic [7:0]  m_acc_x, m_acc_y;
	logic [7:0]  m_x, m_y;
	logic [3:0]  exp_nib;
	logic [7:0]  bk_mem [BRM_BYTES];  // Expected backup image
	int          n_drive, n_checked, n_bk_reset, error_count;
	event        drive_ev;

	pce_io_top i_dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = !clk_sys;

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};  // One step per bit
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	// Expected pad nibble from the inputs and the modelled counters
	function automatic logic [3:0] ref_nibble(input logic s, input logic c);
		logic [31:0] w;
		logic [7:0]  mb;
		logic [1:0]  idx;
		idx = {m_bank, s};
		case (m_port)
			3'd0: w = joy_swap ? joy_b : joy_a;
			3'd1: w = joy_swap ? joy_a : joy_b;
			3'd2: w = joy_2;
			3'd3: w = joy_3;
			default: w = joy_4;
		endcase
		mb[3:0] = ~{w[7], w[6], mouse_flags[0], mouse_flags[1]};
		case (m_nib)
			2'd0: mb[7:4] = m_x[7:4];
			2'd1: mb[7:4] = m_x[3:0];
			2'd2: mb[7:4] = m_y[7:4];
			default: mb[7:4] = m_y[3:0];
		endcase
		if (c)
			return 4'h0;
		if (m_port >= `PCE_PAD_PORTS)
			return (idx == 2'd3) ? 4'h0 : 4'hF;  // Empty tap slot
		if (m_port == 3'd0 && mouse_en)
			return s ? mb[7:4] : mb[3:0];
		case (idx)
			2'd0: return ~w[7:4];
			2'd1: return ~{w[1], w[2], w[0], w[3]};  // Left, down, right, up
			2'd2: return ~w[11:8];
			default: return 4'h0;
		endcase
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got,
	                        input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
			$display("Done: errors found");
			$fatal(1, "Stopped at first error");
		end
	endtask

	task automatic set_modes(input logic tt, input logic b6, input logic me);
		@(negedge clk_sys);
		turbotap = tt;
		buttons6 = b6;
		mouse_en = me;
	endtask

	// Drives a random pad state and updates the model for the checker
	task automatic drive_pad(input logic s, input logic c);
		@(negedge clk_sys);
		joy_a       = rand_bits(32);
		joy_b       = rand_bits(32);
		joy_2       = rand_bits(32);
		joy_3       = rand_bits(32);
		joy_4       = rand_bits(32);
		joy_swap    = 1'(rand_bits(1));
		mouse_flags = 8'(rand_bits(8));
		sel         = s;
		clr         = c;
		if (c) begin
			m_port = '0;
			if (!m_clr_prev) begin
				if (buttons6)
					m_bank = !m_bank;  // 6-button pads alternate banks
				else
					m_bank = 1'b0;
				if (m_nib == 2'd3) begin  // Deltas latched at the end of a round
					m_x     = m_acc_x;
					m_y     = m_acc_y;
					m_acc_x = '0;
					m_acc_y = '0;
				end
				m_nib = m_nib + 2'd1;
			end
		end else if (s && !m_sel_prev && turbotap) begin
			m_port = m_port + 3'd1;
		end
		m_sel_prev = s;
		m_clr_prev = c;
		exp_nib    = ref_nibble(s, c);
		n_drive++;
		-> drive_ev;
		wait (n_checked == n_drive);
	endtask

	task automatic mouse_report();
		@(negedge clk_sys);
		mouse_x      = 9'(rand_bits(9));
		mouse_y      = 9'(rand_bits(9));
		mouse_strobe = 1'b1;
		m_acc_x      = ~mouse_x[7:0] + 8'd1;  // Two's complement of the low byte
		m_acc_y      = mouse_y[7:0];
		@(negedge clk_sys);
		mouse_strobe = 1'b0;
	endtask

	// SD host model with one ack per sector
	// Load writes bytes in and save reads them back
	task automatic serve_image(input logic load);
		int delay;
		for (int s = 0; s < `PCE_SECTORS; s++) begin
			@(negedge clk_sys);
			while (!(sd_rd || sd_wr))
				@(negedge clk_sys);
			check_eq("sd_lba", sd_lba, s);
			check_eq("sd_rd", sd_rd, load);
			check_eq("sd_wr", sd_wr, !load);
			delay = int'(rand_bits(4));
			repeat (delay) @(negedge clk_sys);
			sd_ack = 1'b1;
			for (int a = 0; a <= SECT_BYTES; a++) begin
				if (a > 0 && !load)
					check_eq("sd_buff_din", sd_buff_din, bk_mem[s * SECT_BYTES + a - 1]);
				sd_buff_addr = 9'(a);
				sd_buff_wr   = load && a < SECT_BYTES;
				if (load && a < SECT_BYTES) begin
					sd_buff_dout = 8'(rand_bits(8));
					bk_mem[s * SECT_BYTES + a] = sd_buff_dout;
				end
				@(negedge clk_sys);
			end
			sd_ack     = 1'b0;
			sd_buff_wr = 1'b0;
		end
	endtask

	task automatic console_fill();
		for (int a = 0; a < BRM_BYTES; a++) begin
			@(negedge clk_sys);
			brm_addr  = 11'(a);
			brm_we    = 1'b1;
			brm_wdata = 8'(rand_bits(8));
			bk_mem[a] = brm_wdata;
		end
		@(negedge clk_sys);
		brm_we = 1'b0;
	endtask

	task automatic read_back();
		for (int a = 0; a <= BRM_BYTES; a++) begin
			@(negedge clk_sys);
			if (a > 0)
				check_eq("brm_rdata", brm_rdata, bk_mem[a - 1]);
			brm_addr = 11'(a);  // Data shows up one cycle later
		end
	endtask

	// ====================
	// Checker and monitors
	// ====================

	initial begin
		forever begin
			@(drive_ev);
			repeat (2) @(posedge clk_sys);
			#1;
			check_eq("pad_in", pad_in, exp_nib);
			n_checked++;
		end
	end

	always @(negedge clk_sys) begin
		if (bk_reset)
			n_bk_reset++;
	end

	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, DUT stopped responding", 2 * RUN_CYCLES);
		$display("Done: errors found");
		$fatal(1, "Timeout");
	end

	// ====================
	// Test sequence
	// ====================

	initial begin
		rst = 1'b1;
		{joy_a, joy_b, joy_2, joy_3, joy_4} = '0;
		{joy_swap, turbotap, buttons6, mouse_en, sel, clr} = '0;
		{mouse_x, mouse_y, mouse_flags, mouse_strobe} = '0;
		{brm_addr, brm_we, brm_wdata} = '0;
		{download, mount_strobe, img_size, bk_save} = '0;
		{sd_ack, sd_buff_addr, sd_buff_wr, sd_buff_dout} = '0;
		lfsr       = 32'h217bb0d2;
		m_port     = '0;
		m_bank     = 1'b0;
		m_sel_prev = 1'b0;
		m_clr_prev = 1'b0;
		m_nib      = 2'd3;  // MS_Y_LO after reset
		{m_acc_x, m_acc_y, m_x, m_y} = '0;
		n_drive     = 0;
		n_checked   = 0;
		n_bk_reset  = 0;
		error_count = 0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;

		// Random words on plain pads with swap
		for (int i = 0; i < N_RAND; i++)
			drive_pad(1'(rand_bits(1)), rand_bits(2) == 0);

		// Turbo tap walks past the last port and then holds at port 0
		set_modes(1'b1, 1'b0, 1'b0);
		drive_pad(1'b0, 1'b1);
		repeat (7) begin
			drive_pad(1'b1, 1'b0);
			drive_pad(1'b0, 1'b0);
		end
		set_modes(1'b0, 1'b0, 1'b0);
		drive_pad(1'b0, 1'b1);
		repeat (3) begin
			drive_pad(1'b1, 1'b0);
			drive_pad(1'b0, 1'b0);
		end

		// 6-button bank toggle on and then off
		for (int m = 1; m >= 0; m--) begin
			set_modes(1'b0, 1'(m), 1'b0);
			repeat (5) begin
				drive_pad(1'b0, 1'b1);
				drive_pad(1'b0, 1'b0);
				drive_pad(1'b1, 1'b0);
			end
		end

		// Two mouse rounds where a quiet console forces a restart in the second
		set_modes(1'b0, 1'b0, 1'b1);
		for (int round = 0; round < 2; round++) begin
			if (round == 1 && m_nib == 2'd3) begin
				// Step off MS_Y_LO so the restart changes the sequence
				drive_pad(1'b0, 1'b1);
				drive_pad(1'b0, 1'b0);
			end
			mouse_report();
			if (round == 1) begin
				repeat (MOUSE_WAIT) @(negedge clk_sys);
				m_nib = 2'd3;
			end
			repeat (5) begin
				drive_pad(1'b0, 1'b1);
				drive_pad(1'b0, 1'b0);
				drive_pad(1'b1, 1'b0);
			end
		end
		set_modes(1'b0, 1'b0, 1'b0);

		// Mount loads the image from the host
		@(negedge clk_sys);
		img_size     = 32'(BRM_BYTES);
		mount_strobe = 1'b1;
		@(negedge clk_sys);
		mount_strobe = 1'b0;
		serve_image(1'b1);
		while (n_bk_reset == 0)
			@(negedge clk_sys);
		read_back();
		check_eq("bk_reset pulses", n_bk_reset, 1);

		// Console rewrites the RAM and a save sends it out
		console_fill();
		@(negedge clk_sys);
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		serve_image(1'b0);
		repeat (2) @(negedge clk_sys);  // Where a load would pulse bk_reset
		check_eq("bk_reset pulses", n_bk_reset, 1);

		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
src/pce_io_pkg.sv
src/sd_buf_if.sv
src/pad_mux.sv
src/mouse_track.sv
src/backup_ram.sv
src/backup_sync.sv
src/pce_io_top.sv
verification/pce_io_asserts.sv
verification/pce_io_tb.sv

//--- Makefile
# Verilator build and run of the PCE I/O testbench

VERILATOR ?= verilator
TOP       ?= pce_io_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG) || ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
